/* hw/sq_settings.svh */
`ifndef SQ_SETTINGS_SVH
`define SQ_SETTINGS_SVH

// queue geometry
`define SQ_DEPTH 8
`define SQ_IDX_W 3

// physical address split into line address and byte offset
`define SQ_PADDR_W 32
`define SQ_LINE_BYTES 8
`define SQ_LINE_OFS_W 3
`define SQ_LINE_ADDR_W (`SQ_PADDR_W - `SQ_LINE_OFS_W)

`endif

/* hw/sq_pkg.sv */
`include "sq_settings.svh"

package sq_pkg;

    // queue position, dir flips on every wrap
    typedef struct packed {
        logic                 dir;
        logic [`SQ_IDX_W-1:0] idx;
    } sq_idx_t;

    // one data word, written whole and read per byte lane
    typedef union packed {
        logic [`SQ_LINE_BYTES*8-1:0]    word;
        logic [`SQ_LINE_BYTES-1:0][7:0] lane;
    } sq_data_u;

    typedef struct packed {
        sq_idx_t                    idx;
        logic [`SQ_LINE_ADDR_W-1:0] line_addr;
        logic [`SQ_LINE_BYTES-1:0]  mask;
    } sq_addr_req_t;

    // size: 0 byte, 1 half, 2 word, 3 double
    typedef struct packed {
        sq_idx_t                     idx;
        logic [1:0]                  size;
        logic [`SQ_LINE_BYTES*8-1:0] data;
    } sq_data_req_t;

    typedef struct packed {
        logic                       valid;
        logic                       addr_valid;
        logic                       data_valid;
        logic                       committed;
        logic [`SQ_LINE_ADDR_W-1:0] line_addr;
        logic [`SQ_LINE_BYTES-1:0]  mask;
        sq_data_u                   data;
    } sq_entry_t;

    // sq_idx is the tail seen when the load was dispatched
    typedef struct packed {
        sq_idx_t                    sq_idx;
        logic [`SQ_LINE_ADDR_W-1:0] line_addr;
    } sq_load_req_t;

    typedef struct packed {
        logic [`SQ_LINE_BYTES-1:0] mask;
        sq_data_u                  data;
        logic                      data_invalid;
    } sq_fwd_rsp_t;

    typedef struct packed {
        logic [`SQ_LINE_ADDR_W-1:0]  line_addr;
        logic [`SQ_LINE_BYTES-1:0]   mask;
        logic [`SQ_LINE_BYTES*8-1:0] data;
    } sq_retire_t;

endpackage

/* hw/sq_storage.sv */
`timescale 1ns/100ps
`include "sq_settings.svh"

module sq_storage
    import sq_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         dispatch_i,
    output sq_idx_t      sq_idx_o,
    output logic         full_o,
    input  logic         addr_en_i,
    input  sq_addr_req_t addr_req_i,
    input  logic         data_en_i,
    input  sq_data_req_t data_req_i,
    input  logic         commit_i,
    output logic         commit_empty_o,
    output logic         retire_valid_o,
    output sq_retire_t   retire_o,
    input  logic         retire_conflict_i,
    output sq_entry_t    entries_o [`SQ_DEPTH],
    output sq_idx_t      head_o
);

    // per-entry status bits
    logic [`SQ_DEPTH-1:0] valid_q;
    logic [`SQ_DEPTH-1:0] addr_valid_q;
    logic [`SQ_DEPTH-1:0] data_valid_q;
    logic [`SQ_DEPTH-1:0] committed_q;

    // per-entry payload
    logic [`SQ_LINE_ADDR_W-1:0]  line_addr_q [`SQ_DEPTH];
    logic [`SQ_LINE_BYTES-1:0]   mask_q      [`SQ_DEPTH];
    logic [`SQ_LINE_BYTES*8-1:0] data_q      [`SQ_DEPTH];

    sq_idx_t head_q;
    sq_idx_t tail_q;
    sq_idx_t cmt_q;

    logic dispatch_fire;
    logic retire_fire;

    // carry out of idx lands in dir
    function automatic sq_idx_t next_idx(input sq_idx_t p);
        return sq_idx_t'(p + 1'b1);
    endfunction

    // fill the word with the low bytes of the raw data
    function automatic logic [`SQ_LINE_BYTES*8-1:0] replicate(
        input logic [1:0]                  size,
        input logic [`SQ_LINE_BYTES*8-1:0] raw
    );
        case (size)
            2'd0:    return {8{raw[7:0]}};
            2'd1:    return {4{raw[15:0]}};
            2'd2:    return {2{raw[31:0]}};
            default: return raw;
        endcase
    endfunction

    assign full_o         = (head_q.idx == tail_q.idx) && (head_q.dir != tail_q.dir);
    assign commit_empty_o = (head_q == cmt_q);
    assign dispatch_fire  = dispatch_i & ~full_o;

    assign retire_valid_o = valid_q[head_q.idx] & addr_valid_q[head_q.idx]
                          & data_valid_q[head_q.idx] & committed_q[head_q.idx];
    assign retire_fire    = retire_valid_o & ~retire_conflict_i;

    assign retire_o.line_addr = line_addr_q[head_q.idx];
    assign retire_o.mask      = mask_q[head_q.idx];
    assign retire_o.data      = data_q[head_q.idx];

    assign sq_idx_o = tail_q;
    assign head_o   = head_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q       <= '0;
            tail_q       <= '0;
            cmt_q        <= '0;
            valid_q      <= '0;
            addr_valid_q <= '0;
            data_valid_q <= '0;
            committed_q  <= '0;
        end else begin
            if (dispatch_fire) begin
                valid_q[tail_q.idx]      <= 1'b1;
                addr_valid_q[tail_q.idx] <= 1'b0;
                data_valid_q[tail_q.idx] <= 1'b0;
                committed_q[tail_q.idx]  <= 1'b0;
                tail_q                   <= next_idx(tail_q);
            end
            if (addr_en_i) begin
                addr_valid_q[addr_req_i.idx.idx] <= 1'b1;
            end
            if (data_en_i) begin
                data_valid_q[data_req_i.idx.idx] <= 1'b1;
            end
            if (commit_i) begin
                committed_q[cmt_q.idx] <= 1'b1;
                cmt_q                  <= next_idx(cmt_q);
            end
            // head only moves when the cache accepts
            if (retire_fire) begin
                valid_q[head_q.idx] <= 1'b0;
                head_q              <= next_idx(head_q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_en_i) begin
            line_addr_q[addr_req_i.idx.idx] <= addr_req_i.line_addr;
            mask_q[addr_req_i.idx.idx]      <= addr_req_i.mask;
        end
        if (data_en_i) begin
            data_q[data_req_i.idx.idx] <= replicate(data_req_i.size, data_req_i.data);
        end
    end

    always_comb begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            entries_o[i].valid      = valid_q[i];
            entries_o[i].addr_valid = addr_valid_q[i];
            entries_o[i].data_valid = data_valid_q[i];
            entries_o[i].committed  = committed_q[i];
            entries_o[i].line_addr  = line_addr_q[i];
            entries_o[i].mask       = mask_q[i];
            entries_o[i].data.word  = data_q[i];
        end
    end

endmodule

/* hw/sq_age_window.sv */
`timescale 1ns/100ps
`include "sq_settings.svh"

module sq_age_window
    import sq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_en_i,
    input  sq_load_req_t         load_req_i,
    input  sq_idx_t              head_i,
    input  sq_entry_t            entries_i [`SQ_DEPTH],
    output logic [`SQ_DEPTH-1:0] older_o,
    output logic                 load_valid_o
);

    logic [`SQ_DEPTH-1:0] older_d;
    logic                 same_dir;

    assign same_dir = (load_req_i.sq_idx.dir == head_i.dir);

    // window is [head, load sq_idx), wrapping when the dir bits differ
    always_comb begin
        logic above_head;
        logic below_load;
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            above_head = (`SQ_IDX_W'(i) >= head_i.idx);
            below_load = (`SQ_IDX_W'(i) < load_req_i.sq_idx.idx);
            if (same_dir) begin
                older_d[i] = entries_i[i].valid & above_head & below_load;
            end else begin
                older_d[i] = entries_i[i].valid & (above_head | below_load);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_valid_o <= 1'b0;
        end else begin
            load_valid_o <= load_en_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en_i) begin
            older_o <= older_d;
        end
    end

endmodule

/* hw/sq_addr_match.sv */
`timescale 1ns/100ps
`include "sq_settings.svh"

module sq_addr_match
    import sq_pkg::*;
(
    input  logic                      clk,
    input  logic                      load_en_i,
    input  sq_load_req_t              load_req_i,
    input  sq_entry_t                 entries_i  [`SQ_DEPTH],
    output logic [`SQ_LINE_BYTES-1:0] hit_mask_o [`SQ_DEPTH]
);

    logic [`SQ_LINE_BYTES-1:0] hit_mask_d [`SQ_DEPTH];

    // line compare, byte overlap is resolved later in the merge
    always_comb begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            if (entries_i[i].addr_valid
                && (entries_i[i].line_addr == load_req_i.line_addr)) begin
                hit_mask_d[i] = entries_i[i].mask;
            end else begin
                hit_mask_d[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en_i) begin
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                hit_mask_o[i] <= hit_mask_d[i];
            end
        end
    end

endmodule

/* hw/sq_fwd_merge.sv */
`timescale 1ns/100ps
`include "sq_settings.svh"

module sq_fwd_merge
    import sq_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_valid_i,
    input  logic [`SQ_DEPTH-1:0]      older_i,
    input  logic [`SQ_LINE_BYTES-1:0] hit_mask_i [`SQ_DEPTH],
    input  sq_idx_t                   head_i,
    input  sq_entry_t                 entries_i  [`SQ_DEPTH],
    output logic                      fwd_valid_o,
    output sq_fwd_rsp_t               fwd_o
);

    logic [`SQ_DEPTH-1:0]      cand;
    logic [`SQ_LINE_BYTES-1:0] mask_d;
    logic [`SQ_LINE_BYTES-1:0] inv_d;
    sq_data_u                  data_d;

    always_comb begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            cand[i] = older_i[i] & (|hit_mask_i[i]);
        end
    end

    // oldest first, so a younger store overwrites the byte
    always_comb begin
        logic [`SQ_IDX_W-1:0] pos;
        mask_d      = '0;
        inv_d       = '0;
        data_d.word = '0;
        for (int k = 0; k < `SQ_DEPTH; k++) begin
            pos = head_i.idx + `SQ_IDX_W'(k);
            if (cand[pos]) begin
                for (int b = 0; b < `SQ_LINE_BYTES; b++) begin
                    if (hit_mask_i[pos][b]) begin
                        mask_d[b]      = 1'b1;
                        data_d.lane[b] = entries_i[pos].data.lane[b];
                        inv_d[b]       = ~entries_i[pos].data_valid;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd_valid_o <= 1'b0;
        end else begin
            fwd_valid_o <= load_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        fwd_o.mask         <= mask_d;
        fwd_o.data         <= data_d;
        fwd_o.data_invalid <= |inv_d;
    end

endmodule

/* hw/store_queue.sv */
`timescale 1ns/100ps
`include "sq_settings.svh"

module store_queue
    import sq_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         dispatch_i,
    output sq_idx_t      sq_idx_o,
    output logic         full_o,
    input  logic         addr_en_i,
    input  sq_addr_req_t addr_req_i,
    input  logic         data_en_i,
    input  sq_data_req_t data_req_i,
    input  logic         commit_i,
    output logic         commit_empty_o,
    output logic         retire_valid_o,
    output sq_retire_t   retire_o,
    input  logic         retire_conflict_i,
    input  logic         load_en_i,
    input  sq_load_req_t load_req_i,
    output logic         fwd_valid_o,
    output sq_fwd_rsp_t  fwd_o
);

    sq_entry_t                 entries    [`SQ_DEPTH];
    sq_idx_t                   head;
    logic [`SQ_DEPTH-1:0]      older;
    logic                      load_valid;
    logic [`SQ_LINE_BYTES-1:0] hit_mask   [`SQ_DEPTH];

    sq_storage u_storage (
        .clk               (clk),
        .rst               (rst),
        .dispatch_i        (dispatch_i),
        .sq_idx_o          (sq_idx_o),
        .full_o            (full_o),
        .addr_en_i         (addr_en_i),
        .addr_req_i        (addr_req_i),
        .data_en_i         (data_en_i),
        .data_req_i        (data_req_i),
        .commit_i          (commit_i),
        .commit_empty_o    (commit_empty_o),
        .retire_valid_o    (retire_valid_o),
        .retire_o          (retire_o),
        .retire_conflict_i (retire_conflict_i),
        .entries_o         (entries),
        .head_o            (head)
    );

    // stage one, age and address in parallel
    sq_age_window u_age_window (
        .clk          (clk),
        .rst          (rst),
        .load_en_i    (load_en_i),
        .load_req_i   (load_req_i),
        .head_i       (head),
        .entries_i    (entries),
        .older_o      (older),
        .load_valid_o (load_valid)
    );

    sq_addr_match u_addr_match (
        .clk        (clk),
        .load_en_i  (load_en_i),
        .load_req_i (load_req_i),
        .entries_i  (entries),
        .hit_mask_o (hit_mask)
    );

    // stage two
    sq_fwd_merge u_fwd_merge (
        .clk          (clk),
        .rst          (rst),
        .load_valid_i (load_valid),
        .older_i      (older),
        .hit_mask_i   (hit_mask),
        .head_i       (head),
        .entries_i    (entries),
        .fwd_valid_o  (fwd_valid_o),
        .fwd_o        (fwd_o)
    );

endmodule

/* dv/store_queue_tb.sv */
`timescale 1ns/100ps
`include "sq_settings.svh"

module store_queue_tb
    import sq_pkg::*;
();

    localparam int NUM_FIELDS = 25;

    // one trace line, inputs first and expected outputs after
    typedef struct packed {
        logic                       disp;
        logic                       cmt;
        logic                       aen;
        logic [3:0]                 aidx;
        logic [`SQ_LINE_ADDR_W-1:0] aline;
        logic [7:0]                 amask;
        logic                       den;
        logic [3:0]                 didx;
        logic [1:0]                 dsize;
        logic [63:0]                ddata;
        logic                       len;
        logic [3:0]                 lidx;
        logic [`SQ_LINE_ADDR_W-1:0] lline;
        logic                       conf;
        logic                       efull;
        logic [3:0]                 eidx;
        logic                       ecempty;
        logic                       ervalid;
        logic [`SQ_LINE_ADDR_W-1:0] erline;
        logic [7:0]                 ermask;
        logic [63:0]                erdata;
        logic                       efvalid;
        logic [7:0]                 efmask;
        logic [63:0]                efdata;
        logic                       efinv;
    } trace_line_t;

    logic         clk;
    logic         rst;
    logic         dispatch_i;
    sq_idx_t      sq_idx_o;
    logic         full_o;
    logic         addr_en_i;
    sq_addr_req_t addr_req_i;
    logic         data_en_i;
    sq_data_req_t data_req_i;
    logic         commit_i;
    logic         commit_empty_o;
    logic         retire_valid_o;
    sq_retire_t   retire_o;
    logic         retire_conflict_i;
    logic         load_en_i;
    sq_load_req_t load_req_i;
    logic         fwd_valid_o;
    sq_fwd_rsp_t  fwd_o;

    trace_line_t trace [$];
    int          errors;
    int          checks;
    int          cycle_cnt;
    int          cycle_limit;

    store_queue DUT (
        .clk               (clk),
        .rst               (rst),
        .dispatch_i        (dispatch_i),
        .sq_idx_o          (sq_idx_o),
        .full_o            (full_o),
        .addr_en_i         (addr_en_i),
        .addr_req_i        (addr_req_i),
        .data_en_i         (data_en_i),
        .data_req_i        (data_req_i),
        .commit_i          (commit_i),
        .commit_empty_o    (commit_empty_o),
        .retire_valid_o    (retire_valid_o),
        .retire_o          (retire_o),
        .retire_conflict_i (retire_conflict_i),
        .load_en_i         (load_en_i),
        .load_req_i        (load_req_i),
        .fwd_valid_o       (fwd_valid_o),
        .fwd_o             (fwd_o)
    );

    always #5 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [63:0] f [NUM_FIELDS];
        trace_line_t t;
        fd = $fopen("dv/store_queue_trace.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the trace file");
            errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                f[20], f[21], f[22], f[23], f[24]);
            if (n != NUM_FIELDS) begin
                $display("error: trace line has %0d fields instead of %0d", n, NUM_FIELDS);
                errors++;
                continue;
            end
            t = {f[0][0], f[1][0], f[2][0], f[3][3:0], f[4][`SQ_LINE_ADDR_W-1:0], f[5][7:0],
                 f[6][0], f[7][3:0], f[8][1:0], f[9], f[10][0], f[11][3:0],
                 f[12][`SQ_LINE_ADDR_W-1:0], f[13][0], f[14][0], f[15][3:0], f[16][0],
                 f[17][0], f[18][`SQ_LINE_ADDR_W-1:0], f[19][7:0], f[20], f[21][0],
                 f[22][7:0], f[23], f[24][0]};
            trace.push_back(t);
        end
        $fclose(fd);
    endtask

    task automatic drive_line(input trace_line_t t);
        dispatch_i           <= t.disp;
        commit_i             <= t.cmt;
        addr_en_i            <= t.aen;
        addr_req_i.idx       <= t.aidx;
        addr_req_i.line_addr <= t.aline;
        addr_req_i.mask      <= t.amask;
        data_en_i            <= t.den;
        data_req_i.idx       <= t.didx;
        data_req_i.size      <= t.dsize;
        data_req_i.data      <= t.ddata;
        load_en_i            <= t.len;
        load_req_i.sq_idx    <= t.lidx;
        load_req_i.line_addr <= t.lline;
        retire_conflict_i    <= t.conf;
    endtask

    task automatic check_line(input trace_line_t t);
        check_val("full_o", t.efull, full_o);
        check_val("sq_idx_o", t.eidx, sq_idx_o);
        check_val("commit_empty_o", t.ecempty, commit_empty_o);
        check_val("retire_valid_o", t.ervalid, retire_valid_o);
        if (t.ervalid) begin
            check_val("retire_o.line_addr", t.erline, retire_o.line_addr);
            check_val("retire_o.mask", t.ermask, retire_o.mask);
            check_val("retire_o.data", t.erdata, retire_o.data);
        end
        check_val("fwd_valid_o", t.efvalid, fwd_valid_o);
        if (t.efvalid) begin
            check_val("fwd_o.mask", t.efmask, fwd_o.mask);
            check_val("fwd_o.data_invalid", t.efinv, fwd_o.data_invalid);
            // data is meaningless once a winning store lacks it
            if (!t.efinv) begin
                check_val("fwd_o.data", t.efdata, fwd_o.data.word);
            end
        end
    endtask

    // stop a run that never reaches its end
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("error: timeout, run exceeded %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        dispatch_i        = 1'b0;
        addr_en_i         = 1'b0;
        addr_req_i        = '0;
        data_en_i         = 1'b0;
        data_req_i        = '0;
        commit_i          = 1'b0;
        retire_conflict_i = 1'b0;
        load_en_i         = 1'b0;
        load_req_i        = '0;
        errors            = 0;
        checks            = 0;
        cycle_cnt         = 0;
        cycle_limit       = 1000;

        load_trace();
        cycle_limit = trace.size() + 20;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        foreach (trace[i]) begin
            @(posedge clk);
            drive_line(trace[i]);
            @(negedge clk);
            check_line(trace[i]);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* dv/store_queue_trace.txt */
# in:  disp cmt aen aidx aline amask den didx dsize ddata len lidx lline conf
# out: full sq_idx cempty rvalid rline rmask rdata fvalid fmask fdata finv
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5 1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 7 1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 1 0 010 01 1 0 0 00000000000000a5 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 1 1 011 03 1 1 1 0000000000001234 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 1 2 012 0f 1 2 2 0000000089abcdef 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 1 3 013 ff 1 3 3 0123456789abcdef 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 1 4 040 0f 1 4 3 4444444444444444 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 1 5 040 3c 1 5 3 5555555555555555 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 1 6 040 ff 1 6 3 6666666666666666 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 1 7 070 0f 0 0 0 0 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 1 6 040 0 1 8 1 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 1 8 070 0 1 8 1 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 1 8 040 0 1 8 1 0 0 0 0 1 3f 0000555555554444 0
0 0 0 0 0 0 0 0 0 0 1 6 055 0 1 8 1 0 0 0 0 1 0f 0 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8 1 0 0 0 0 1 ff 6666666666666666 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8 1 0 0 0 0 1 00 0 0
0 1 0 0 0 0 0 0 0 0 0 0 0 0 1 8 1 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 8 0 1 010 01 a5a5a5a5a5a5a5a5 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 8 0 1 010 01 a5a5a5a5a5a5a5a5 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8 0 1 010 01 a5a5a5a5a5a5a5a5 0 0 0 0
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 8 1 0 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 8 0 1 011 03 1234123412341234 0 0 0 0
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 8 0 1 012 0f 89abcdef89abcdef 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 0 1 013 ff 0123456789abcdef 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 1 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 1 0 0 0 0 0 0 0 0

/* build.f */
+incdir+hw
hw/sq_pkg.sv
hw/sq_storage.sv
hw/sq_age_window.sv
hw/sq_addr_match.sv
hw/sq_fwd_merge.sv
hw/store_queue.sv
dv/store_queue_tb.sv

/* Bender.yml */
package:
  name: store_queue

sources:
  - include_dirs:
      - hw
    files:
      - hw/sq_pkg.sv
      - hw/sq_storage.sv
      - hw/sq_age_window.sv
      - hw/sq_addr_match.sv
      - hw/sq_fwd_merge.sv
      - hw/store_queue.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/store_queue_tb.sv
